/* src.f */
+incdir+src
src/dac_pkg.sv
src/timed_fifo.sv
src/dds_generator.sv
src/direct_sample_path.sv
src/dac_output_select.sv
src/dac_controller.sv
tb/tb_dac_controller.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the DAC controller testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -f src.f \
    --top-module tb_dac_controller -o tb_sim \
    && ./obj_dir/tb_sim | tee sim.log

grep -q '^Testbench passed$' sim.log && echo "Simulation PASSED" \
    || { echo "Simulation FAILED"; exit 1; }

/* tb/tb_dac_controller.sv */
`timescale 1ns/1ps
`include "dac_params.svh"

module tb_dac_controller import dac_pkg::*; ();

    localparam logic [1:0] KIND_DDS    = 2'd0;
    localparam logic [1:0] KIND_DIRECT = 2'd1;
    localparam logic [1:0] KIND_PAIR   = 2'd2;  // Two entries due together
    localparam int         NUM_ROWS    = 5;

    typedef struct packed {
        logic                          mode;       // dac_mode while the row runs
        logic [1:0]                    kind;       // Expected output shape
        logic                          rand_fill;  // Payloads from $urandom
        logic [15:0]                   ts_offset;  // Cycles from write to due time
        logic [`DAC_PAYLOAD_WIDTH-1:0] payload;
        logic [`DAC_PAYLOAD_WIDTH-1:0] payload2;   // Second entry of a pair
    } stim_row_t;

    logic                     s_axi_aclk;
    logic                     reset;
    logic                     cmd_write;
    fifo_entry_t              cmd_entry;
    logic                     flush;
    logic                     mode_write;
    logic                     mode_value;
    logic                     auto_start;
    logic [`DAC_TS_WIDTH-1:0] counter;     // Time controller model
    dac_stream_t              m00_axis;
    logic                     full;
    logic                     empty;
    logic                     dac_mode;
    stim_row_t                rows [NUM_ROWS];
    int                       cycles;
    int                       cycle_limit;

    dac_controller u_dac_controller (.*);

    initial begin
        s_axi_aclk = 1'b0;
        forever #20 s_axi_aclk = ~s_axi_aclk;  // 40 ns period
    end

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////
    // One clock with inputs driven 2 ns after the edge
    task automatic tick();
        @(posedge s_axi_aclk);
        #2;
        counter = counter + 1;
        cycles++;
        if (cycles > cycle_limit) begin
            $display("Timeout: run exceeded its limit of %0d cycles", cycle_limit);
            $display("Testbench failed");
            $fatal(1, "simulation stopped");
        end
    endtask

    task automatic check(input bit ok, input string msg);
        assert (ok) else begin
            $display("CHECK FAILED at %0t: %s", $time, msg);
            $display("Testbench failed");
            $fatal(1, "stopped at first error");
        end
    endtask

    task automatic apply_reset();
        reset = 1'b1;
        repeat (3) tick();
        reset = 1'b0;
    endtask

    task automatic set_mode(input logic value);
        mode_write = 1'b1;
        mode_value = value;
        tick();
        mode_write = 1'b0;
        check(dac_mode == value, $sformatf("dac_mode %0b, expected %0b", dac_mode, value));
    endtask

    // Entry is stored at the edge ending this cycle
    task automatic write_entry(input logic [`DAC_TS_WIDTH-1:0] ts,
                               input logic [`DAC_PAYLOAD_WIDTH-1:0] payload);
        cmd_write           = 1'b1;
        cmd_entry.timestamp = ts;
        cmd_entry.payload   = payload;
        tick();
        cmd_write = 1'b0;
    endtask

    // Pop cycle plus 3 is where tvalid first shows
    task automatic wait_for_output(input logic [63:0] due);
        while (!m00_axis.tvalid) tick();
        check(counter == due, $sformatf("first tvalid at %0d, expected %0d", counter, due));
    endtask

    // Sawtooth reference for word n after the load
    function automatic logic [63:0] dds_expected(input dds_cmd_t cmd, input int n);
        logic [31:0]        base;
        logic [31:0]        lane_phase;
        logic signed [15:0] top;
        longint             scaled;
        logic [63:0]        word;
        base = {cmd.phase, 18'd0} + 32'(4 * n) * cmd.freq;
        for (int k = 0; k < `DAC_LANES; k++) begin
            lane_phase = base + 32'(k) * cmd.freq;
            top        = lane_phase[31:16];
            scaled     = (longint'(top) * longint'({50'd0, cmd.amp})) >>> 14;
            word[k*16 +: 16] = scaled[15:0];
        end
        return word;
    endfunction

    ////////////////////////////////////////////////////////////
    // Test sequences
    ////////////////////////////////////////////////////////////
    task automatic run_row(input stim_row_t row);
        logic [63:0] ts;
        apply_reset();
        if (row.mode) set_mode(1'b1);
        auto_start = 1'b1;
        ts = counter + 64'(row.ts_offset);
        write_entry(ts, row.payload);
        if (row.kind == KIND_PAIR) write_entry(ts, row.payload2);  // Same due time
        wait_for_output(ts + 3);
        if (row.kind == KIND_DDS) begin
            for (int n = 0; n < 6; n++) begin
                check(m00_axis.tvalid && m00_axis.tdata == dds_expected(row.payload, n),
                      $sformatf("DDS word %0d is %h", n, m00_axis.tdata));
                tick();
            end
        end else begin
            check(m00_axis.tdata == row.payload, $sformatf("direct word %h", m00_axis.tdata));
            tick();
            if (row.kind == KIND_PAIR) begin
                check(m00_axis.tvalid && m00_axis.tdata == row.payload2,
                      $sformatf("second direct word %h", m00_axis.tdata));
                tick();
            end
            check(!m00_axis.tvalid, "direct tvalid longer than one cycle");
        end
    endtask

    task automatic gating_sequence();
        logic [63:0] cmd;
        cmd = {32'h0200_0000, 14'h1000, 14'h2000, 4'h0};
        apply_reset();
        auto_start = 1'b0;
        write_entry(counter, cmd);  // Already due
        repeat (8) begin
            tick();
            check(!m00_axis.tvalid && !empty, "entry left queue with auto_start low");
        end
        auto_start = 1'b1;
        wait_for_output(counter + 3);
        check(m00_axis.tdata == dds_expected(cmd, 0), "gated DDS word wrong");
    endtask

    task automatic queue_limit_sequence();
        logic [63:0] ts;
        int          released;
        apply_reset();
        set_mode(1'b1);
        auto_start = 1'b1;
        ts         = counter + 30;  // Far beyond the writes
        released   = 0;
        for (int i = 0; i < `DAC_FIFO_DEPTH; i++) write_entry(ts, {4{16'(i + 1)}});
        check(full, "full low after filling queue");
        write_entry(ts, {4{16'hdead}});  // Dropped
        while (counter < ts + 22) begin
            tick();
            if (m00_axis.tvalid) begin
                check(m00_axis.tdata == {4{16'(released + 1)}},
                      $sformatf("release %0d carries %h", released, m00_axis.tdata));
                released++;
            end
        end
        check(released == `DAC_FIFO_DEPTH, $sformatf("%0d releases seen", released));
        check(empty, "queue not empty after all releases");
    endtask

    task automatic flush_sequence();
        logic [63:0] ts;
        ts = counter + 6;
        write_entry(ts, 64'h0101_0202_0303_0404);
        write_entry(ts, 64'h0505_0606_0707_0808);
        flush = 1'b1;
        write_entry(ts, 64'h0909_0a0a_0b0b_0c0c);  // Flush wins
        flush = 1'b0;
        check(empty, "empty low after flush");
        while (counter < ts + 10) begin
            tick();
            check(!m00_axis.tvalid, "output after flush");
        end
    endtask

    task automatic mode_register_sequence();
        apply_reset();
        auto_start = 1'b0;
        write_entry(counter, 64'h0);
        check(!empty, "queue empty after write");
        mode_write = 1'b1;
        mode_value = 1'b1;
        tick();
        mode_write = 1'b0;
        check(dac_mode == 1'b0, "mode changed while queue not empty");
        flush = 1'b1;
        tick();
        flush = 1'b0;
        check(empty, "empty low after flush");
        set_mode(1'b1);
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////
    initial begin
        int offset_sum;
        void'($urandom(32'h3d72_59cc));
        reset      = 1'b1;
        cmd_write  = 1'b0;
        cmd_entry  = '0;
        flush      = 1'b0;
        mode_write = 1'b0;
        mode_value = 1'b0;
        auto_start = 1'b0;
        counter    = '0;
        cycles     = 0;
        offset_sum = 0;
        rows[0] = '{1'b0, KIND_DDS, 1'b0, 16'd8, {32'h0100_0000, 14'h0, 14'h3fff, 4'h0}, 64'h0};
        rows[1] = '{1'b0, KIND_DDS, 1'b1, 16'd12, 64'h0, 64'h0};
        rows[2] = '{1'b1, KIND_DIRECT, 1'b0, 16'd6, 64'h8000_7fff_1234_fedc, 64'h0};
        rows[3] = '{1'b1, KIND_DIRECT, 1'b1, 16'd10, 64'h0, 64'h0};
        rows[4] = '{1'b1, KIND_PAIR, 1'b1, 16'd9, 64'h0, 64'h0};
        for (int r = 0; r < NUM_ROWS; r++) begin
            if (rows[r].rand_fill) begin
                rows[r].payload  = {$urandom, $urandom};
                rows[r].payload2 = {$urandom, $urandom};
            end
            offset_sum += int'(rows[r].ts_offset);
        end
        cycle_limit = 4 * offset_sum + 200;

        apply_reset();
        check(!m00_axis.tvalid && m00_axis.tdata == '0, "stream not idle after reset");
        check(empty && !full && !dac_mode, "status wrong after reset");
        gating_sequence();
        for (int r = 0; r < NUM_ROWS; r++) run_row(rows[r]);
        queue_limit_sequence();
        flush_sequence();
        mode_register_sequence();

        $display("Testbench passed");
        $finish;
    end

endmodule

/* src/dac_controller.sv */
`timescale 1ns/1ps
`include "dac_params.svh"

module dac_controller import dac_pkg::*; (
    input  logic                     s_axi_aclk,
    input  logic                     reset,
    // Command queue
    input  logic                     cmd_write,
    input  fifo_entry_t              cmd_entry,
    input  logic                     flush,
    // Mode control
    input  logic                     mode_write,
    input  logic                     mode_value,
    // Time controller
    input  logic                     auto_start,
    input  logic [`DAC_TS_WIDTH-1:0] counter,
    // Sample stream and status
    output dac_stream_t              m00_axis,
    output logic                     full,
    output logic                     empty,
    output logic                     dac_mode
);

    fifo_release_t release_bus;    // Popped payload to both paths
    dac_stream_t   dds_stream;
    dac_stream_t   direct_stream;

    ////////////////////////////////////////////////////////////
    // Timestamped queue
    ////////////////////////////////////////////////////////////
    timed_fifo u_timed_fifo (
        .s_axi_aclk  (s_axi_aclk),
        .reset       (reset),
        .write       (cmd_write),
        .din         (cmd_entry),
        .flush       (flush),
        .auto_start  (auto_start),
        .counter     (counter),
        .release_bus (release_bus),
        .full        (full),
        .empty       (empty)
    );

    ////////////////////////////////////////////////////////////
    // Sample paths, both always listening
    ////////////////////////////////////////////////////////////
    dds_generator u_dds_generator (
        .s_axi_aclk  (s_axi_aclk),
        .reset       (reset),
        .release_bus (release_bus),
        .dac_mode    (dac_mode),
        .dds_stream  (dds_stream)
    );

    direct_sample_path u_direct_sample_path (
        .s_axi_aclk    (s_axi_aclk),
        .reset         (reset),
        .release_bus   (release_bus),
        .dac_mode      (dac_mode),
        .direct_stream (direct_stream)
    );

    // Mode register and stream output
    dac_output_select u_dac_output_select (
        .s_axi_aclk    (s_axi_aclk),
        .reset         (reset),
        .mode_write    (mode_write),
        .mode_value    (mode_value),
        .empty         (empty),
        .dds_stream    (dds_stream),
        .direct_stream (direct_stream),
        .m00_axis      (m00_axis),
        .dac_mode      (dac_mode)
    );

endmodule

/* src/dac_output_select.sv */
`timescale 1ns/1ps

module dac_output_select import dac_pkg::*; (
    input  logic        s_axi_aclk,
    input  logic        reset,
    input  logic        mode_write,     // Mode update strobe
    input  logic        mode_value,
    input  logic        empty,          // Queue empty, mode may change
    input  dac_stream_t dds_stream,
    input  dac_stream_t direct_stream,
    output dac_stream_t m00_axis,
    output logic        dac_mode        // 0 DDS, 1 direct
);

    dac_stream_t                   sel;
    logic [$bits(sel.tdata)-1:0]   tdata_r;
    logic                          tvalid_r;

    ////////////////////////////////////////////////////////////
    // Mode register
    ////////////////////////////////////////////////////////////
    always_ff @(posedge s_axi_aclk) begin
        if (reset) begin
            dac_mode <= 1'b0;
        end else if (mode_write && empty) begin
            dac_mode <= mode_value;  // Ignored while commands are pending
        end
    end

    ////////////////////////////////////////////////////////////
    // Path select and output register
    ////////////////////////////////////////////////////////////
    assign sel = dac_mode ? direct_stream : dds_stream;

    always_ff @(posedge s_axi_aclk) begin
        if (reset) begin
            tvalid_r <= 1'b0;
            tdata_r  <= '0;
        end else begin
            tvalid_r <= sel.tvalid;
            if (sel.tvalid) begin
                tdata_r <= sel.tdata;  // Last valid word kept otherwise
            end
        end
    end

    assign m00_axis = '{tdata: tdata_r, tvalid: tvalid_r};

endmodule

/* src/direct_sample_path.sv */
`timescale 1ns/1ps

module direct_sample_path import dac_pkg::*; (
    input  logic          s_axi_aclk,
    input  logic          reset,
    input  fifo_release_t release_bus,
    input  logic          dac_mode,       // 1 selects raw samples
    output dac_stream_t   direct_stream
);

    logic         capture;
    direct_word_t data_r;   // Last released sample word
    logic         valid_r;

    ////////////////////////////////////////////////////////////
    // Capture of raw samples
    ////////////////////////////////////////////////////////////
    assign capture = release_bus.valid && (dac_mode == 1'b1);

    // One-cycle pulse per release
    always_ff @(posedge s_axi_aclk) begin
        if (reset) begin
            valid_r <= 1'b0;
        end else begin
            valid_r <= capture;
        end
    end

    always_ff @(posedge s_axi_aclk) begin
        if (capture) begin
            data_r <= release_bus.payload.samples;  // Lanes pass unchanged
        end
    end

    // Data held between releases
    assign direct_stream = '{tdata: data_r, tvalid: valid_r};

endmodule

/* src/dds_generator.sv */
`timescale 1ns/1ps
`include "dac_params.svh"

module dds_generator import dac_pkg::*; (
    input  logic          s_axi_aclk,
    input  logic          reset,
    input  fifo_release_t release_bus,
    input  logic          dac_mode,    // 0 selects tone commands
    output dac_stream_t   dds_stream
);

    localparam int FW = `DAC_FREQ_WIDTH;
    localparam int AW = `DAC_AMP_WIDTH;
    localparam int SW = `DAC_SAMPLE_WIDTH;
    localparam int NL = `DAC_LANES;

    logic [FW-1:0]      acc;       // Phase of lane0 for the next word
    logic [FW-1:0]      freq_r;
    logic [AW-1:0]      amp_r;
    logic [FW-1:0]      acc_src;
    logic [FW-1:0]      freq_src;
    logic [AW-1:0]      amp_src;
    logic               load;
    logic               active;    // Running since first tone command
    logic [NL*SW-1:0]   word;
    logic [NL*SW-1:0]   tdata_r;
    logic               tvalid_r;

    // Sawtooth sample, top bits of lane phase scaled by amp
    function automatic logic [SW-1:0] lane_sample(
        input logic [FW-1:0] base,
        input logic [FW-1:0] step,
        input logic [AW-1:0] gain,
        input int            k
    );
        logic [FW-1:0]          lane_phase;
        logic signed [SW+AW:0]  prod;
        lane_phase = base + step * FW'(k);
        prod = $signed(lane_phase[FW-1 -: SW]) * $signed({1'b0, gain});
        return prod[AW+SW-1:AW];  // Arithmetic shift right by AW
    endfunction

    assign load = release_bus.valid && (dac_mode == 1'b0);

    ////////////////////////////////////////////////////////////
    // Source of this cycle's word
    ////////////////////////////////////////////////////////////
    always_comb begin
        if (load) begin
            // Fresh command, phase in top bits of accumulator
            acc_src  = {release_bus.payload.dds.phase, {(FW - `DAC_PHASE_WIDTH){1'b0}}};
            freq_src = release_bus.payload.dds.freq;
            amp_src  = release_bus.payload.dds.amp;
        end else begin
            acc_src  = acc;
            freq_src = freq_r;
            amp_src  = amp_r;
        end
    end

    always_comb begin
        for (int k = 0; k < NL; k++) begin
            word[k*SW +: SW] = lane_sample(acc_src, freq_src, amp_src, k);
        end
    end

    ////////////////////////////////////////////////////////////
    // Accumulator and output registers
    ////////////////////////////////////////////////////////////
    always_ff @(posedge s_axi_aclk) begin
        if (reset) begin
            active   <= 1'b0;
            acc      <= '0;
            tvalid_r <= 1'b0;
        end else if (load || active) begin
            active   <= 1'b1;
            acc      <= acc_src + (freq_src << 2);  // Four lanes per clock
            tvalid_r <= 1'b1;  // Stays high until reset
        end
    end

    always_ff @(posedge s_axi_aclk) begin
        if (load || active) begin
            freq_r  <= freq_src;
            amp_r   <= amp_src;
            tdata_r <= word;
        end
    end

    assign dds_stream = '{tdata: tdata_r, tvalid: tvalid_r};

endmodule

/* src/timed_fifo.sv */
`timescale 1ns/1ps
`include "dac_params.svh"

module timed_fifo import dac_pkg::*; (
    input  logic                     s_axi_aclk,
    input  logic                     reset,
    input  logic                     write,       // Push strobe
    input  fifo_entry_t              din,
    input  logic                     flush,       // Drop all entries
    input  logic                     auto_start,  // Release enable
    input  logic [`DAC_TS_WIDTH-1:0] counter,     // Free-running time
    output fifo_release_t            release_bus,
    output logic                     full,
    output logic                     empty
);

    localparam int DEPTH = `DAC_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    fifo_entry_t        mem [DEPTH];  // Entry storage
    logic [PTR_W-1:0]   rd_ptr;
    logic [PTR_W-1:0]   wr_ptr;
    logic [CNT_W-1:0]   count;
    fifo_entry_t        head;
    logic               pop;
    logic               push;
    logic               rel_valid;
    dac_payload_u       rel_payload;

    ////////////////////////////////////////////////////////////
    // Release and push decisions
    ////////////////////////////////////////////////////////////
    assign head  = mem[rd_ptr];
    assign empty = (count == '0);
    assign full  = (count == CNT_W'(DEPTH));

    // At most one pop per cycle when the head is due
    assign pop  = auto_start && !empty && !flush && (counter >= head.timestamp);
    // Full queue still takes a write when the head leaves this cycle
    assign push = write && !flush && (!full || pop);

    ////////////////////////////////////////////////////////////
    // Pointers and occupancy
    ////////////////////////////////////////////////////////////
    always_ff @(posedge s_axi_aclk) begin
        if (reset || flush) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // Both or neither
            endcase
        end
    end

    // Storage write
    always_ff @(posedge s_axi_aclk) begin
        if (push) begin
            mem[wr_ptr] <= din;
        end
    end

    ////////////////////////////////////////////////////////////
    // Registered release word
    ////////////////////////////////////////////////////////////
    always_ff @(posedge s_axi_aclk) begin
        if (reset) begin
            rel_valid <= 1'b0;
        end else begin
            rel_valid <= pop;  // High the cycle after the pop edge
        end
    end

    always_ff @(posedge s_axi_aclk) begin
        if (pop) begin
            rel_payload <= head.payload;
        end
    end

    assign release_bus = '{valid: rel_valid, payload: rel_payload};

endmodule

/* src/dac_pkg.sv */
`include "dac_params.svh"

package dac_pkg;

    ////////////////////////////////////////////////////////////
    // Payload views
    ////////////////////////////////////////////////////////////

    // Tone command, DDS mode
    typedef struct packed {
        logic [`DAC_FREQ_WIDTH-1:0]  freq;   // Phase step per sample
        logic [`DAC_PHASE_WIDTH-1:0] phase;  // Start phase, top bits of accumulator
        logic [`DAC_AMP_WIDTH-1:0]   amp;    // Unsigned gain
        logic [3:0]                  pad;
    } dds_cmd_t;

    // Raw samples, direct mode
    typedef struct packed {
        logic signed [`DAC_SAMPLE_WIDTH-1:0] lane3;  // Last in time
        logic signed [`DAC_SAMPLE_WIDTH-1:0] lane2;
        logic signed [`DAC_SAMPLE_WIDTH-1:0] lane1;
        logic signed [`DAC_SAMPLE_WIDTH-1:0] lane0;  // First in time
    } direct_word_t;

    // Same 64 bits, meaning set by dac_mode
    typedef union packed {
        dds_cmd_t     dds;
        direct_word_t samples;
    } dac_payload_u;

    ////////////////////////////////////////////////////////////
    // Queue and stream words
    ////////////////////////////////////////////////////////////
    typedef struct packed {
        logic [`DAC_TS_WIDTH-1:0] timestamp;
        dac_payload_u             payload;
    } fifo_entry_t;

    typedef struct packed {
        logic         valid;    // One cycle per popped entry
        dac_payload_u payload;
    } fifo_release_t;

    typedef struct packed {
        logic [`DAC_LANES*`DAC_SAMPLE_WIDTH-1:0] tdata;  // lane0 in low bits
        logic                                    tvalid;
    } dac_stream_t;

endpackage

/* src/dac_params.svh */
`ifndef DAC_PARAMS_SVH
`define DAC_PARAMS_SVH

////////////////////////////////////////////////////////////
// Timing and payload widths
////////////////////////////////////////////////////////////
`define DAC_TS_WIDTH      64   // Timestamp, matches time controller counter
`define DAC_PAYLOAD_WIDTH 64   // One command payload word

// Command queue
`define DAC_FIFO_DEPTH    16

////////////////////////////////////////////////////////////
// Sample stream
////////////////////////////////////////////////////////////
`define DAC_LANES         4    // Samples per stream word
`define DAC_SAMPLE_WIDTH  16
`define DAC_FREQ_WIDTH    32   // Phase increment and accumulator
`define DAC_PHASE_WIDTH   14
`define DAC_AMP_WIDTH     14

`endif
